/* logic/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    // csr operation of the retiring instruction
    typedef enum logic [1:0] {
        CSR_NONE = 2'b00,
        CSR_RW   = 2'b01,
        CSR_RS   = 2'b10,
        CSR_RC   = 2'b11
    } csr_op_e;

    // supported machine-mode csr numbers
    typedef enum logic [11:0] {
        CSR_MSTATUS   = 12'h300,
        CSR_MISA      = 12'h301,
        CSR_MIE       = 12'h304,
        CSR_MTVEC     = 12'h305,
        CSR_MSCRATCH  = 12'h340,
        CSR_MEPC      = 12'h341,
        CSR_MCAUSE    = 12'h342,
        CSR_MIP       = 12'h344,
        CSR_MCYCLE    = 12'hB00,
        CSR_MINSTRET  = 12'hB02,
        CSR_MVENDORID = 12'hF11,
        CSR_MARCHID   = 12'hF12,
        CSR_MIMPID    = 12'hF13,
        CSR_MHARTID   = 12'hF14
    } csr_addr_e;

    // exception codes, interrupt flag goes on top
    localparam logic [3:0] CAUSE_ECALL_M    = 4'd11;
    localparam logic [3:0] CAUSE_BREAKPOINT = 4'd3;
    localparam logic [3:0] CAUSE_TIMER_IRQ  = 4'd7;

    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_MPP_LO = 11;

    localparam logic [31:0] MSTATUS_WMASK = 32'h0000_1888;
    localparam logic [31:0] MIE_WMASK     = 32'h0000_0080;
    localparam int          MIP_MTIP_BIT  = 7;

endpackage

`default_nettype wire

/* logic/trap_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface trap_if #(
    parameter int XLEN = 64
);

    // trap controller side
    logic            take_trap;
    logic            take_mret;
    logic            is_irq;
    logic [3:0]      cause_code;
    logic [XLEN-1:0] epc;

    // csr file side
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic            mstatus_mie;
    logic            mie_mtie;

    modport ctrl (
        output take_trap, take_mret, is_irq, cause_code, epc,
        input  mtvec, mepc, mstatus_mie, mie_mtie
    );

    modport csr (
        input  take_trap, take_mret, is_irq, cause_code, epc,
        output mtvec, mepc, mstatus_mie, mie_mtie
    );

endinterface

`default_nettype wire

/* logic/csr_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_regfile #(
    parameter int          XLEN    = 64,
    parameter int unsigned HART_ID = 0
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              inst_valid,
    input  csr_pkg::csr_op_e  csr_op,
    input  logic [11:0]       csr_addr,
    input  logic              csr_src,
    input  logic [XLEN-1:0]   rs1_data,
    input  logic [XLEN-1:0]   imm_data,
    input  logic              mtip,
    output logic [XLEN-1:0]   csr_rdata,
    trap_if.csr               trap
);
    import csr_pkg::*;

    localparam logic [1:0]      MXL          = (XLEN == 64) ? 2'd2 : 2'd1;
    localparam logic [XLEN-1:0] MISA_VAL     = {MXL, {(XLEN-28){1'b0}}, 26'h000_0100};
    localparam logic [XLEN-1:0] MHARTID_VAL  = XLEN'(HART_ID);
    localparam logic [XLEN-1:0] ZERO_VAL     = '0;
    localparam logic [XLEN-1:0] MSTATUS_MASK = XLEN'(MSTATUS_WMASK);
    localparam logic [XLEN-1:0] MIE_MASK     = XLEN'(MIE_WMASK);
    localparam logic [XLEN-1:0] MTVEC_MASK   = ~XLEN'(3);

    logic sel_mstatus;
    logic sel_misa;
    logic sel_mie;
    logic sel_mtvec;
    logic sel_mscratch;
    logic sel_mepc;
    logic sel_mcause;
    logic sel_mip;
    logic sel_mcycle;
    logic sel_minstret;
    logic sel_mvendorid;
    logic sel_marchid;
    logic sel_mimpid;
    logic sel_mhartid;

    logic [XLEN-1:0] mstatus_q;
    logic [XLEN-1:0] mie_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mscratch_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;
    logic [XLEN-1:0] mcycle_q;
    logic [XLEN-1:0] minstret_q;
    logic [XLEN-1:0] mip_val;

    logic [XLEN-1:0] operand;
    logic [XLEN-1:0] wdata;
    logic            csr_wr;
    logic            retire;

    assign sel_mstatus   = (csr_addr == CSR_MSTATUS);
    assign sel_misa      = (csr_addr == CSR_MISA);
    assign sel_mie       = (csr_addr == CSR_MIE);
    assign sel_mtvec     = (csr_addr == CSR_MTVEC);
    assign sel_mscratch  = (csr_addr == CSR_MSCRATCH);
    assign sel_mepc      = (csr_addr == CSR_MEPC);
    assign sel_mcause    = (csr_addr == CSR_MCAUSE);
    assign sel_mip       = (csr_addr == CSR_MIP);
    assign sel_mcycle    = (csr_addr == CSR_MCYCLE);
    assign sel_minstret  = (csr_addr == CSR_MINSTRET);
    assign sel_mvendorid = (csr_addr == CSR_MVENDORID);
    assign sel_marchid   = (csr_addr == CSR_MARCHID);
    assign sel_mimpid    = (csr_addr == CSR_MIMPID);
    assign sel_mhartid   = (csr_addr == CSR_MHARTID);

    // mtip is live, nothing stored
    assign mip_val = XLEN'(mtip) << MIP_MTIP_BIT;

    // unknown address falls through to zero
    assign csr_rdata = ({XLEN{sel_mstatus}}   & mstatus_q)
                     | ({XLEN{sel_misa}}      & MISA_VAL)
                     | ({XLEN{sel_mie}}       & mie_q)
                     | ({XLEN{sel_mtvec}}     & mtvec_q)
                     | ({XLEN{sel_mscratch}}  & mscratch_q)
                     | ({XLEN{sel_mepc}}      & mepc_q)
                     | ({XLEN{sel_mcause}}    & mcause_q)
                     | ({XLEN{sel_mip}}       & mip_val)
                     | ({XLEN{sel_mcycle}}    & mcycle_q)
                     | ({XLEN{sel_minstret}}  & minstret_q)
                     | ({XLEN{sel_mvendorid}} & ZERO_VAL)
                     | ({XLEN{sel_marchid}}   & ZERO_VAL)
                     | ({XLEN{sel_mimpid}}    & ZERO_VAL)
                     | ({XLEN{sel_mhartid}}   & MHARTID_VAL);

    assign operand = csr_src ? imm_data : rs1_data;

    always_comb begin
        case (csr_op)
            CSR_RW:  wdata = operand;
            CSR_RS:  wdata = csr_rdata | operand;
            CSR_RC:  wdata = csr_rdata & ~operand;
            default: wdata = csr_rdata;
        endcase
    end

    // trap and mret both outrank the csr op
    assign csr_wr = inst_valid && (csr_op != CSR_NONE) && !trap.take_trap && !trap.take_mret;
    assign retire = inst_valid && !trap.take_trap;

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_q <= '0;
        end else if (csr_wr && sel_mstatus) begin
            mstatus_q <= wdata & MSTATUS_MASK;
        end else if (trap.take_trap) begin
            mstatus_q[MSTATUS_MPIE]        <= mstatus_q[MSTATUS_MIE];
            mstatus_q[MSTATUS_MIE]         <= 1'b0;
            mstatus_q[MSTATUS_MPP_LO +: 2] <= 2'b11;
        end else if (trap.take_mret) begin
            mstatus_q[MSTATUS_MIE]         <= mstatus_q[MSTATUS_MPIE];
            mstatus_q[MSTATUS_MPIE]        <= 1'b1;
            mstatus_q[MSTATUS_MPP_LO +: 2] <= 2'b00;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mie_q      <= MIE_MASK;
            mtvec_q    <= '0;
            mscratch_q <= '0;
        end else if (csr_wr) begin
            if (sel_mie) begin
                mie_q <= wdata & MIE_MASK;
            end
            if (sel_mtvec) begin
                mtvec_q <= wdata & MTVEC_MASK;
            end
            if (sel_mscratch) begin
                mscratch_q <= wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mepc_q   <= '0;
            mcause_q <= '0;
        end else if (trap.take_trap) begin
            mepc_q   <= trap.epc;
            mcause_q <= {trap.is_irq, {(XLEN-5){1'b0}}, trap.cause_code};
        end else if (csr_wr) begin
            if (sel_mepc) begin
                mepc_q <= wdata;
            end
            if (sel_mcause) begin
                mcause_q <= wdata;
            end
        end
    end

    // counters, a csr write wins over the increment
    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle_q   <= '0;
            minstret_q <= '0;
        end else begin
            if (csr_wr && sel_mcycle) begin
                mcycle_q <= wdata;
            end else begin
                mcycle_q <= mcycle_q + XLEN'(1);
            end
            if (csr_wr && sel_minstret) begin
                minstret_q <= wdata;
            end else if (retire) begin
                minstret_q <= minstret_q + XLEN'(1);
            end
        end
    end

    assign trap.mtvec       = mtvec_q;
    assign trap.mepc        = mepc_q;
    assign trap.mstatus_mie = mstatus_q[MSTATUS_MIE];
    assign trap.mie_mtie    = mie_q[MIP_MTIP_BIT];

endmodule

`default_nettype wire

/* logic/trap_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl #(
    parameter int XLEN = 64
) (
    input  logic            inst_valid,
    input  logic            inst_ecall,
    input  logic            inst_ebreak,
    input  logic            inst_mret,
    input  logic [XLEN-1:0] inst_addr,
    input  logic            mtip,
    output logic            redirect,
    output logic [XLEN-1:0] redirect_pc,
    trap_if.ctrl            trap
);
    import csr_pkg::*;

    logic irq_pending;
    logic exc_pending;
    logic trap_now;
    logic mret_now;

    // timer interrupt needs both enables
    assign irq_pending = mtip && trap.mstatus_mie && trap.mie_mtie;
    assign exc_pending = inst_ecall || inst_ebreak;

    assign trap_now = inst_valid && (irq_pending || exc_pending);
    assign mret_now = inst_valid && !irq_pending && !exc_pending && inst_mret;

    always_comb begin
        if (irq_pending) begin
            trap.cause_code = CAUSE_TIMER_IRQ;
        end else if (inst_ecall) begin
            trap.cause_code = CAUSE_ECALL_M;
        end else begin
            trap.cause_code = CAUSE_BREAKPOINT;
        end
    end

    assign trap.take_trap = trap_now;
    assign trap.take_mret = mret_now;
    assign trap.is_irq    = irq_pending;
    assign trap.epc       = inst_addr;

    // same-cycle redirect to the handler or back to mepc
    assign redirect    = trap_now || mret_now;
    assign redirect_pc = trap_now ? trap.mtvec : trap.mepc;

endmodule

`default_nettype wire

/* logic/clint_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module clint_timer #(
    parameter int TICK_DIV = 1
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        mtip
);

    localparam int          DIV_W   = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(TICK_DIV - 1);

    localparam logic [11:0] OFF_CMP_LO  = 12'h000;
    localparam logic [11:0] OFF_CMP_HI  = 12'h004;
    localparam logic [11:0] OFF_TIME_LO = 12'h008;
    localparam logic [11:0] OFF_TIME_HI = 12'h00C;

    logic [DIV_W-1:0] div_cnt;
    logic             tick;
    logic [63:0]      mtime_q;
    logic [63:0]      mtimecmp_q;
    logic             access;
    logic             wr_en;
    logic             addr_ok;
    logic [31:0]      rd_data;

    assign access = psel && penable;
    assign wr_en  = access && pwrite;

    always_comb begin
        rd_data = '0;
        addr_ok = 1'b1;
        case (paddr)
            OFF_CMP_LO:  rd_data = mtimecmp_q[31:0];
            OFF_CMP_HI:  rd_data = mtimecmp_q[63:32];
            OFF_TIME_LO: rd_data = mtime_q[31:0];
            OFF_TIME_HI: rd_data = mtime_q[63:32];
            default:     addr_ok = 1'b0;
        endcase
    end

    // no wait states
    assign pready  = 1'b1;
    assign prdata  = access ? rd_data : '0;
    assign pslverr = access && !addr_ok;

    // prescaler
    assign tick = (div_cnt == DIV_LAST);

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
        end else if (tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + DIV_W'(1);
        end
    end

    // apb write beats the tick
    always_ff @(posedge clk) begin
        if (rst) begin
            mtime_q <= '0;
        end else if (wr_en && paddr == OFF_TIME_LO) begin
            mtime_q[31:0] <= pwdata;
        end else if (wr_en && paddr == OFF_TIME_HI) begin
            mtime_q[63:32] <= pwdata;
        end else if (tick) begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtimecmp_q <= '1;
        end else if (wr_en && paddr == OFF_CMP_LO) begin
            mtimecmp_q[31:0] <= pwdata;
        end else if (wr_en && paddr == OFF_CMP_HI) begin
            mtimecmp_q[63:32] <= pwdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtip <= 1'b0;
        end else begin
            mtip <= (mtime_q >= mtimecmp_q);
        end
    end

endmodule

`default_nettype wire

/* logic/csr_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_subsystem #(
    parameter int          XLEN     = 64,
    parameter int unsigned HART_ID  = 0,
    parameter int          TICK_DIV = 2
) (
    input  logic             clk,
    input  logic             rst,

    // retiring instruction
    input  logic             inst_valid,
    input  logic [XLEN-1:0]  inst_addr,
    input  csr_pkg::csr_op_e csr_op,
    input  logic [11:0]      csr_addr,
    input  logic             csr_src,
    input  logic [XLEN-1:0]  rs1_data,
    input  logic [XLEN-1:0]  imm_data,
    input  logic             inst_ecall,
    input  logic             inst_ebreak,
    input  logic             inst_mret,
    output logic [XLEN-1:0]  csr_rdata,
    output logic             redirect,
    output logic [XLEN-1:0]  redirect_pc,

    // timer registers over apb
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  logic [11:0]      paddr,
    input  logic [31:0]      pwdata,
    output logic [31:0]      prdata,
    output logic             pready,
    output logic             pslverr
);

    logic mtip;

    trap_if #(.XLEN(XLEN)) trap_bus ();

    csr_regfile #(
        .XLEN    (XLEN),
        .HART_ID (HART_ID)
    ) u_csr_regfile (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .csr_op     (csr_op),
        .csr_addr   (csr_addr),
        .csr_src    (csr_src),
        .rs1_data   (rs1_data),
        .imm_data   (imm_data),
        .mtip       (mtip),
        .csr_rdata  (csr_rdata),
        .trap       (trap_bus.csr)
    );

    trap_ctrl #(
        .XLEN (XLEN)
    ) u_trap_ctrl (
        .inst_valid  (inst_valid),
        .inst_ecall  (inst_ecall),
        .inst_ebreak (inst_ebreak),
        .inst_mret   (inst_mret),
        .inst_addr   (inst_addr),
        .mtip        (mtip),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .trap        (trap_bus.ctrl)
    );

    clint_timer #(
        .TICK_DIV (TICK_DIV)
    ) u_clint_timer (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .mtip    (mtip)
    );

endmodule

`default_nettype wire

/* tb/csr_subsystem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_subsystem_tb;
    import csr_pkg::*;

    localparam int          XLEN     = 64;
    localparam int unsigned HART_ID  = 5;
    localparam int          TICK_DIV = 2;
    localparam int          NUM_RMW  = 200;
    // each rmw pass is two instructions of two cycles, plus reset and the fixed tests
    localparam int          RUN_CYCLES     = 16 + 4 * NUM_RMW + 184;
    localparam int          TIMEOUT_CYCLES = 4 * RUN_CYCLES;

    logic             clk;
    logic             rst;
    logic             inst_valid;
    logic [XLEN-1:0]  inst_addr;
    csr_op_e          csr_op;
    logic [11:0]      csr_addr;
    logic             csr_src;
    logic [XLEN-1:0]  rs1_data;
    logic [XLEN-1:0]  imm_data;
    logic             inst_ecall;
    logic             inst_ebreak;
    logic             inst_mret;
    logic [XLEN-1:0]  csr_rdata;
    logic             redirect;
    logic [XLEN-1:0]  redirect_pc;
    logic             psel;
    logic             penable;
    logic             pwrite;
    logic [11:0]      paddr;
    logic [31:0]      pwdata;
    logic [31:0]      prdata;
    logic             pready;
    logic             pslverr;

    // reference model of the writable csrs
    logic [63:0] m_mstatus;
    logic [63:0] m_mie;
    logic [63:0] m_mtvec;
    logic [63:0] m_mscratch;
    logic [63:0] m_mepc;
    logic [63:0] m_mcause;
    logic        tip;
    int          retired;

    int          cycles = 0;
    integer      seed = 32'h63612fd2;
    logic [63:0] last_rdata;
    int          last_cycle;
    logic [31:0] apb_rdata;
    logic        apb_err;
    int          apb_cycle;

    csr_subsystem #(
        .XLEN     (XLEN),
        .HART_ID  (HART_ID),
        .TICK_DIV (TICK_DIV)
    ) uut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic check_cond(input string name, input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("%s: %s", name, what);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    // {known, value}
    function automatic logic [64:0] model_read(input logic [11:0] addr);
        case (addr)
            CSR_MSTATUS:  return {1'b1, m_mstatus};
            CSR_MIE:      return {1'b1, m_mie};
            CSR_MTVEC:    return {1'b1, m_mtvec};
            CSR_MSCRATCH: return {1'b1, m_mscratch};
            CSR_MEPC:     return {1'b1, m_mepc};
            CSR_MCAUSE:   return {1'b1, m_mcause};
            default:      return {1'b0, 64'd0};
        endcase
    endfunction

    task automatic model_write(input logic [11:0] addr, input logic [63:0] val);
        case (addr)
            CSR_MSTATUS:  m_mstatus = val & 64'h1888;
            CSR_MIE:      m_mie = val & 64'h80;
            CSR_MTVEC:    m_mtvec = {val[63:2], 2'b00};
            CSR_MSCRATCH: m_mscratch = val;
            CSR_MEPC:     m_mepc = val;
            CSR_MCAUSE:   m_mcause = val;
            default:      ;
        endcase
    endtask

    task automatic run_inst(input string name, input csr_op_e op, input logic [11:0] addr,
                            input logic src, input logic [63:0] rs1, input logic [63:0] imm,
                            input logic ecall, input logic ebreak, input logic mret,
                            input logic [63:0] pc);
        logic [64:0] old;
        logic [63:0] operand;
        logic [63:0] new_val;
        logic        irq;
        logic        trap;
        logic        ret;
        @(negedge clk);
        inst_valid  = 1'b1;
        inst_addr   = pc;
        csr_op      = op;
        csr_addr    = addr;
        csr_src     = src;
        rs1_data    = rs1;
        imm_data    = imm;
        inst_ecall  = ecall;
        inst_ebreak = ebreak;
        inst_mret   = mret;
        @(posedge clk);
        last_rdata = csr_rdata;
        last_cycle = cycles;
        irq  = tip && m_mstatus[3] && m_mie[7];
        trap = irq || ecall || ebreak;
        ret  = !trap && mret;
        check_value({name, " redirect"}, 64'(trap || ret), 64'(redirect));
        if (trap || ret) begin
            check_value({name, " redirect_pc"}, trap ? m_mtvec : m_mepc, redirect_pc);
        end
        old = model_read(addr);
        if (old[64]) begin
            check_value({name, " rdata"}, old[63:0], csr_rdata);
        end
        if (trap) begin
            m_mepc   = pc;
            m_mcause = irq ? {1'b1, 59'd0, 4'd7} : (ecall ? 64'd11 : 64'd3);
            m_mstatus[7]     = m_mstatus[3];
            m_mstatus[3]     = 1'b0;
            m_mstatus[12:11] = 2'b11;
        end else begin
            retired++;
            if (ret) begin
                m_mstatus[3]     = m_mstatus[7];
                m_mstatus[7]     = 1'b1;
                m_mstatus[12:11] = 2'b00;
            end else if (op != CSR_NONE) begin
                operand = src ? imm : rs1;
                case (op)
                    CSR_RW:  new_val = operand;
                    CSR_RS:  new_val = old[63:0] | operand;
                    default: new_val = old[63:0] & ~operand;
                endcase
                model_write(addr, new_val);
            end
        end
        @(negedge clk);
        inst_valid  = 1'b0;
        csr_op      = CSR_NONE;
        inst_ecall  = 1'b0;
        inst_ebreak = 1'b0;
        inst_mret   = 1'b0;
    endtask

    task automatic read_csr(input string name, input logic [11:0] addr);
        run_inst(name, CSR_NONE, addr, 1'b0, 64'd0, 64'd0, 1'b0, 1'b0, 1'b0, 64'd0);
    endtask

    task automatic write_csr(input string name, input csr_op_e op, input logic [11:0] addr,
                             input logic [63:0] val);
        run_inst(name, op, addr, 1'b0, val, 64'd0, 1'b0, 1'b0, 1'b0, 64'd0);
    endtask

    task automatic sys_inst(input string name, input logic ecall, input logic ebreak,
                            input logic mret, input logic [63:0] pc);
        run_inst(name, CSR_NONE, 12'h000, 1'b0, 64'd0, 64'd0, ecall, ebreak, mret, pc);
    endtask

    task automatic apb_xfer(input logic write, input logic [11:0] addr, input logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        apb_rdata = prdata;
        apb_err   = pslverr;
        apb_cycle = cycles;
        check_value("apb pready", 64'd1, 64'(pready));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    initial begin
        logic [11:0] addr;
        csr_op_e     op;
        logic [63:0] rnd;
        logic [31:0] cmp_lo;
        logic [31:0] cmp_hi;
        logic [63:0] cnt_a;
        int          at_a;
        int          r_first;
        int          r_second;
        clk = 1'b0;
        rst = 1'b1;
        inst_valid = 1'b0;
        inst_addr = '0;
        csr_op = CSR_NONE;
        csr_addr = '0;
        csr_src = 1'b0;
        rs1_data = '0;
        imm_data = '0;
        inst_ecall = 1'b0;
        inst_ebreak = 1'b0;
        inst_mret = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        m_mstatus = '0;
        m_mie = 64'h80;
        m_mtvec = '0;
        m_mscratch = '0;
        m_mepc = '0;
        m_mcause = '0;
        tip = 1'b0;
        retired = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // reset values, model holds the writable ones
        read_csr("reset mstatus", CSR_MSTATUS);
        read_csr("reset mtvec", CSR_MTVEC);
        read_csr("reset mepc", CSR_MEPC);
        read_csr("reset mcause", CSR_MCAUSE);
        read_csr("reset mscratch", CSR_MSCRATCH);
        read_csr("reset mie", CSR_MIE);
        read_csr("reset misa", CSR_MISA);
        check_value("reset misa", (64'd2 << 62) | (64'd1 << 8), last_rdata);
        read_csr("reset mhartid", CSR_MHARTID);
        check_value("reset mhartid", 64'(HART_ID), last_rdata);
        read_csr("unknown csr", 12'h7C0);
        check_value("unknown csr", 64'd0, last_rdata);
        apb_xfer(1'b0, 12'h000, 32'd0);
        check_value("reset mtimecmp lo", 64'hFFFF_FFFF, 64'(apb_rdata));
        apb_xfer(1'b0, 12'h004, 32'd0);
        check_value("reset mtimecmp hi", 64'hFFFF_FFFF, 64'(apb_rdata));

        for (int i = 0; i < NUM_RMW; i++) begin
            case ($unsigned($random(seed)) % 4)
                0:       addr = CSR_MSCRATCH;
                1:       addr = CSR_MTVEC;
                2:       addr = CSR_MSTATUS;
                default: addr = CSR_MIE;
            endcase
            op  = csr_op_e'(2'd1 + 2'($unsigned($random(seed)) % 3));
            rnd = {$random(seed), $random(seed)};
            run_inst($sformatf("rmw %0d", i), op, addr, rnd[0], rnd,
                     64'(rnd[12:8]), 1'b0, 1'b0, 1'b0, 64'd0);
            read_csr($sformatf("rmw %0d readback", i), addr);
        end

        // ecall, mret, ebreak, mret
        write_csr("exc mtvec", CSR_RW, CSR_MTVEC, 64'h0000_0000_8000_1000);
        write_csr("exc mstatus", CSR_RW, CSR_MSTATUS, 64'h8);
        sys_inst("ecall", 1'b1, 1'b0, 1'b0, 64'h0000_0000_8000_0104);
        read_csr("ecall mepc", CSR_MEPC);
        check_value("ecall mepc", 64'h0000_0000_8000_0104, last_rdata);
        read_csr("ecall mcause", CSR_MCAUSE);
        check_value("ecall mcause", 64'd11, last_rdata);
        read_csr("ecall mstatus", CSR_MSTATUS);
        check_value("ecall mstatus", 64'h1880, last_rdata);
        sys_inst("mret after ecall", 1'b0, 1'b0, 1'b1, 64'h0000_0000_8000_1040);
        read_csr("mret mstatus", CSR_MSTATUS);
        check_value("mret mstatus", 64'h88, last_rdata);
        // mie off so the ebreak saves a zero mpie
        write_csr("ebreak mie off", CSR_RC, CSR_MSTATUS, 64'h8);
        sys_inst("ebreak", 1'b0, 1'b1, 1'b0, 64'h0000_0000_8000_0220);
        read_csr("ebreak mepc", CSR_MEPC);
        check_value("ebreak mepc", 64'h0000_0000_8000_0220, last_rdata);
        read_csr("ebreak mcause", CSR_MCAUSE);
        check_value("ebreak mcause", 64'd3, last_rdata);
        read_csr("ebreak mstatus", CSR_MSTATUS);
        check_value("ebreak mstatus", 64'h1800, last_rdata);
        sys_inst("mret after ebreak", 1'b0, 1'b0, 1'b1, 64'h0000_0000_8000_1080);
        read_csr("mret mpie", CSR_MSTATUS);
        check_value("mret mpie", 64'h80, last_rdata);

        // counters
        r_first = retired;
        read_csr("minstret first", CSR_MINSTRET);
        cnt_a = last_rdata;
        read_csr("cnt mscratch", CSR_MSCRATCH);
        write_csr("cnt write", CSR_RW, CSR_MSCRATCH, {$random(seed), $random(seed)});
        sys_inst("cnt ecall", 1'b1, 1'b0, 1'b0, 64'h0000_0000_8000_0300);
        sys_inst("cnt mret", 1'b0, 1'b0, 1'b1, 64'h0000_0000_8000_1000);
        r_second = retired;
        read_csr("minstret second", CSR_MINSTRET);
        check_value("minstret delta", 64'(r_second - r_first), last_rdata - cnt_a);
        read_csr("mcycle first", CSR_MCYCLE);
        cnt_a = last_rdata;
        at_a  = last_cycle;
        repeat (9) @(negedge clk);
        read_csr("mcycle second", CSR_MCYCLE);
        check_value("mcycle delta", 64'(last_cycle - at_a), last_rdata - cnt_a);

        // timer over apb, compare kept far above mtime
        cmp_lo = $random(seed);
        cmp_hi = $random(seed) | 32'h8000_0000;
        apb_xfer(1'b1, 12'h000, cmp_lo);
        apb_xfer(1'b1, 12'h004, cmp_hi);
        apb_xfer(1'b0, 12'h000, 32'd0);
        check_value("mtimecmp lo readback", 64'(cmp_lo), 64'(apb_rdata));
        check_value("mtimecmp lo pslverr", 64'd0, 64'(apb_err));
        apb_xfer(1'b0, 12'h004, 32'd0);
        check_value("mtimecmp hi readback", 64'(cmp_hi), 64'(apb_rdata));
        apb_xfer(1'b0, 12'h010, 32'd0);
        check_value("bad offset pslverr", 64'd1, 64'(apb_err));
        check_value("bad offset prdata", 64'd0, 64'(apb_rdata));
        apb_xfer(1'b0, 12'h008, 32'd0);
        cmp_lo = apb_rdata;
        at_a   = apb_cycle;
        repeat (7) @(negedge clk);
        apb_xfer(1'b0, 12'h008, 32'd0);
        check_cond("mtime order", apb_rdata >= cmp_lo, "mtime low went backwards");
        check_cond("mtime rate", (apb_rdata - cmp_lo) <= 32'(apb_cycle - at_a),
                   "mtime advanced more than the elapsed cycles");

        // timer interrupt, enables first
        write_csr("irq mie off", CSR_RW, CSR_MIE, 64'd0);
        write_csr("irq mstatus on", CSR_RS, CSR_MSTATUS, 64'h8);
        apb_xfer(1'b1, 12'h000, 32'h20);
        apb_xfer(1'b1, 12'h004, 32'h0);
        repeat (3) @(negedge clk);
        tip = 1'b1;
        read_csr("irq mip mtie off", CSR_MIP);
        check_value("irq mip mtie off", 64'h80, last_rdata);
        write_csr("irq mstatus off", CSR_RC, CSR_MSTATUS, 64'h8);
        write_csr("irq mie on", CSR_RW, CSR_MIE, 64'h80);
        read_csr("irq mip mie off", CSR_MIP);
        check_value("irq mip mie off", 64'h80, last_rdata);
        write_csr("irq mstatus on again", CSR_RS, CSR_MSTATUS, 64'h8);
        // interrupt outranks the ecall in the same cycle
        sys_inst("irq with ecall", 1'b1, 1'b0, 1'b0, 64'h0000_0000_8000_0400);
        read_csr("irq mcause", CSR_MCAUSE);
        check_value("irq mcause", 64'h8000_0000_0000_0007, last_rdata);
        read_csr("irq mepc", CSR_MEPC);
        check_value("irq mepc", 64'h0000_0000_8000_0400, last_rdata);

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
logic/csr_pkg.sv
logic/trap_if.sv
logic/csr_regfile.sv
logic/trap_ctrl.sv
logic/clint_timer.sv
logic/csr_subsystem.sv
tb/csr_subsystem_tb.sv

/* Bender.yml */
package:
  name: csr_subsystem

sources:
  - logic/csr_pkg.sv
  - logic/trap_if.sv
  - logic/csr_regfile.sv
  - logic/trap_ctrl.sv
  - logic/clint_timer.sv
  - logic/csr_subsystem.sv
  - target: simulation
    files:
      - tb/csr_subsystem_tb.sv
